/* logic/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// integer register and datapath width
`define XLEN 64

// architectural registers x0..x31
`define NR_REG 32

// bits needed to index one register
`define REG_SEL 5

// first fetch address out of reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

/* logic/rv_isa_pkg.sv */
`include "core_defines.svh"

package rv_isa_pkg;

	// base formats, fields from bit 31 down to bit 0
	typedef struct packed {
		logic [6:0]          funct7;
		logic [`REG_SEL-1:0] rs2;
		logic [`REG_SEL-1:0] rs1;
		logic [2:0]          funct3;
		logic [`REG_SEL-1:0] rd;
		logic [6:0]          opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]         imm;
		logic [`REG_SEL-1:0] rs1;
		logic [2:0]          funct3;
		logic [`REG_SEL-1:0] rd;
		logic [6:0]          opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]          imm_hi; // imm[11:5]
		logic [`REG_SEL-1:0] rs2;
		logic [`REG_SEL-1:0] rs1;
		logic [2:0]          funct3;
		logic [4:0]          imm_lo; // imm[4:0]
		logic [6:0]          opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0]         imm; // imm[31:12]
		logic [`REG_SEL-1:0] rd;
		logic [6:0]          opcode;
	} u_fmt_t;

	// jal offset bits come scrambled
	typedef struct packed {
		logic                imm20;
		logic [9:0]          imm10_1;
		logic                imm11;
		logic [7:0]          imm19_12;
		logic [`REG_SEL-1:0] rd;
		logic [6:0]          opcode;
	} j_fmt_t;

	// same 32 bits, read through whichever format applies
	typedef union packed {
		logic [31:0] raw;
		r_fmt_t      r;
		i_fmt_t      i;
		s_fmt_t      s;
		u_fmt_t      u;
		j_fmt_t      j;
	} inst_word_u;

	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

endpackage

/* logic/core_ctrl_pkg.sv */
package core_ctrl_pkg;

	// operation handed from decode to execute
	typedef enum logic [2:0] {
		OP_ADDI    = 3'd0,
		OP_JALR    = 3'd1,
		OP_AUIPC   = 3'd2,
		OP_LUI     = 3'd3,
		OP_SD      = 3'd4,
		OP_JAL     = 3'd5,
		OP_EBREAK  = 3'd6,
		OP_ILLEGAL = 3'd7   // no-op
	} op_e;

	// one-hot format class, all zero when no operand is needed
	typedef enum logic [3:0] {
		FMT_NONE = 4'b0000,
		FMT_I    = 4'b0001,
		FMT_S    = 4'b0010,
		FMT_U    = 4'b0100,
		FMT_J    = 4'b1000
	} fmt_e;

endpackage

/* logic/gpr_file.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module gpr_file (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`REG_SEL-1:0] rs1,
	input  logic [`REG_SEL-1:0] rs2,
	input  logic [`REG_SEL-1:0] rd,
	input  logic                wen,
	input  logic [`XLEN-1:0]    wdata,
	output logic [`XLEN-1:0]    rdata1,
	output logic [`XLEN-1:0]    rdata2
);

	logic [`XLEN-1:0]   regs [`NR_REG];
	logic [`NR_REG-1:0] reg_wen; // one-hot per register

	// x0 never gets an enable, so writes to it vanish
	assign reg_wen = (wen && rd != '0) ? (`NR_REG'(1) << rd) : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NR_REG; i++)
				regs[i] <= '0;
		end else begin
			for (int i = 0; i < `NR_REG; i++) begin
				if (reg_wen[i])
					regs[i] <= wdata;
			end
		end
	end

	// x0 reads zero even before the first reset
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/inst_decode.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module inst_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [31:0]         inst,
	input  logic [`XLEN-1:0]    pc,
	input  logic                wb_en,
	input  logic [`XLEN-1:0]    wb_data,
	output core_ctrl_pkg::op_e  op,
	output logic [`XLEN-1:0]    src1,
	output logic [`XLEN-1:0]    src2,
	output logic [`XLEN-1:0]    store_data,
	output logic [`REG_SEL-1:0] rd
);

	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	inst_word_u       iw;
	fmt_e             fmt;
	logic             u_pc_rel; // auipc adds pc, lui adds zero
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;

	assign iw.raw = inst;
	assign rd     = iw.r.rd;

	// opcode to operation and operand format
	always_comb begin
		op       = core_ctrl_pkg::OP_ILLEGAL;
		fmt      = FMT_NONE;
		u_pc_rel = 1'b0;
		case (iw.r.opcode)
			rv_isa_pkg::OP_IMM: begin
				if (iw.i.funct3 == 3'b000) begin // addi only
					op  = core_ctrl_pkg::OP_ADDI;
					fmt = FMT_I;
				end
			end
			rv_isa_pkg::OP_JALR: begin
				if (iw.i.funct3 == 3'b000) begin
					op  = core_ctrl_pkg::OP_JALR;
					fmt = FMT_I;
				end
			end
			rv_isa_pkg::OP_AUIPC: begin
				op       = core_ctrl_pkg::OP_AUIPC;
				fmt      = FMT_U;
				u_pc_rel = 1'b1;
			end
			rv_isa_pkg::OP_LUI: begin
				op  = core_ctrl_pkg::OP_LUI;
				fmt = FMT_U;
			end
			rv_isa_pkg::OP_STORE: begin
				if (iw.s.funct3 == 3'b011) begin // doubleword
					op  = core_ctrl_pkg::OP_SD;
					fmt = FMT_S;
				end
			end
			rv_isa_pkg::OP_JAL: begin
				op  = core_ctrl_pkg::OP_JAL;
				fmt = FMT_J;
			end
			rv_isa_pkg::OP_SYSTEM: begin
				// ebreak is the one exact word 0x00100073
				if (iw.i.imm == 12'd1 && iw.i.rs1 == '0 &&
						iw.i.funct3 == 3'b000 && iw.i.rd == '0)
					op = core_ctrl_pkg::OP_EBREAK;
			end
			default: ;
		endcase
	end

	// sign-extended immediates
	assign imm_i = {{(`XLEN-12){iw.i.imm[11]}}, iw.i.imm};
	assign imm_s = {{(`XLEN-12){iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
	assign imm_u = {{(`XLEN-32){iw.u.imm[19]}}, iw.u.imm, 12'b0};
	assign imm_j = {{(`XLEN-21){iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12,
			iw.j.imm11, iw.j.imm10_1, 1'b0};

	always_comb begin
		src1       = '0;
		src2       = '0;
		store_data = '0;
		case (fmt)
			FMT_I: begin
				src1 = rs1_val;
				src2 = imm_i;
			end
			FMT_S: begin
				src1       = rs1_val;
				src2       = imm_s;
				store_data = rs2_val;
			end
			FMT_U: begin
				src1 = u_pc_rel ? pc : '0;
				src2 = imm_u;
			end
			FMT_J: begin
				src1 = pc;
				src2 = imm_j;
			end
			default: ; // ebreak and illegal carry zeros
		endcase
	end

	gpr_file u_gpr (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs1    (iw.r.rs1),
		.rs2    (iw.r.rs2),
		.rd     (iw.r.rd),
		.wen    (wb_en),
		.wdata  (wb_data),
		.rdata1 (rs1_val),
		.rdata2 (rs2_val)
	);

endmodule

/* logic/exec_unit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module exec_unit (
	input  logic [`XLEN-1:0]    pc,
	input  logic                run,
	input  core_ctrl_pkg::op_e  op,
	input  logic [`XLEN-1:0]    src1,
	input  logic [`XLEN-1:0]    src2,
	input  logic [`XLEN-1:0]    store_data,
	input  logic [`REG_SEL-1:0] rd,
	output logic [`XLEN-1:0]    next_pc,
	output logic                halt_req,
	output logic                wb_en,
	output logic [`REG_SEL-1:0] wb_addr,
	output logic [`XLEN-1:0]    wb_data,
	output logic                store_en,
	output logic [`XLEN-1:0]    store_addr,
	output logic [`XLEN-1:0]    store_data_out
);

	import core_ctrl_pkg::*;

	logic [`XLEN-1:0] sum;    // shared adder, result or target or address
	logic [`XLEN-1:0] pc_inc;
	logic             wb_req;

	assign sum    = src1 + src2;
	assign pc_inc = pc + `XLEN'd4;

	always_comb begin
		next_pc  = pc_inc;
		wb_data  = sum;
		wb_req   = 1'b0;
		halt_req = 1'b0;
		case (op)
			OP_ADDI, OP_LUI, OP_AUIPC: wb_req = 1'b1;
			OP_JAL: begin
				wb_req  = 1'b1;
				wb_data = pc_inc; // link
				next_pc = sum;
			end
			OP_JALR: begin
				wb_req  = 1'b1;
				wb_data = pc_inc;
				next_pc = {sum[`XLEN-1:1], 1'b0};
			end
			OP_EBREAK: begin
				next_pc  = pc; // stay put
				halt_req = 1'b1;
			end
			default: ; // sd and illegal just step on
		endcase
	end

	assign wb_en          = run && wb_req && (rd != '0);
	assign wb_addr        = rd;
	assign store_en       = run && (op == OP_SD);
	assign store_addr     = sum;
	assign store_data_out = store_data;

endmodule

/* logic/fetch_pc.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module fetch_pc (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [`XLEN-1:0] next_pc,
	input  logic             halt_req,
	output logic [`XLEN-1:0] pc,
	output logic             halted,
	output logic             run
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc     <= `RESET_PC;
			halted <= 1'b0;
		end else if (!halted) begin
			pc     <= next_pc;
			halted <= halt_req; // sticky until reset
		end
	end

	// commit qualifier for write-back and store
	assign run = rst_n && !halted;

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module rv_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [31:0]         inst,
	output logic [`XLEN-1:0]    pc,
	output logic                halted,
	output logic                wb_en,
	output logic [`REG_SEL-1:0] wb_addr,
	output logic [`XLEN-1:0]    wb_data,
	output logic                store_en,
	output logic [`XLEN-1:0]    store_addr,
	output logic [`XLEN-1:0]    store_data
);

	import core_ctrl_pkg::*;

	op_e                 op;
	logic [`XLEN-1:0]    src1;
	logic [`XLEN-1:0]    src2;
	logic [`XLEN-1:0]    dec_store_data; // rs2 value for sd
	logic [`REG_SEL-1:0] rd;
	logic [`XLEN-1:0]    next_pc;
	logic                halt_req;
	logic                run;

	fetch_pc u_fetch (
		.clk      (clk),
		.rst_n    (rst_n),
		.next_pc  (next_pc),
		.halt_req (halt_req),
		.pc       (pc),
		.halted   (halted),
		.run      (run)
	);

	inst_decode u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.pc         (pc),
		.wb_en      (wb_en),
		.wb_data    (wb_data),
		.op         (op),
		.src1       (src1),
		.src2       (src2),
		.store_data (dec_store_data),
		.rd         (rd)
	);

	exec_unit u_exec (
		.pc             (pc),
		.run            (run),
		.op             (op),
		.src1           (src1),
		.src2           (src2),
		.store_data     (dec_store_data),
		.rd             (rd),
		.next_pc        (next_pc),
		.halt_req       (halt_req),
		.wb_en          (wb_en),
		.wb_addr        (wb_addr),
		.wb_data        (wb_data),
		.store_en       (store_en),
		.store_addr     (store_addr),
		.store_data_out (store_data)
	);

endmodule

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_rv_core;

	import rv_isa_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int NROWS      = 15;
	localparam int K_ADDI     = 0;
	localparam int K_JALR     = 1;
	localparam int K_AUIPC    = 2;
	localparam int K_LUI      = 3;
	localparam int K_SD       = 4;
	localparam int K_JAL      = 5;
	localparam int K_EBREAK   = 6;
	localparam int K_ILLEGAL  = 7;

	logic                clk;
	logic                rst_n;
	logic [31:0]         inst;
	logic [`XLEN-1:0]    pc;
	logic                halted;
	logic                wb_en;
	logic [`REG_SEL-1:0] wb_addr;
	logic [`XLEN-1:0]    wb_data;
	logic                store_en;
	logic [`XLEN-1:0]    store_addr;
	logic [`XLEN-1:0]    store_data;

	// program table with model-filled expected columns
	logic [31:0]         tbl_inst [NROWS];
	logic [`XLEN-1:0]    exp_pc [NROWS];
	logic                exp_halted [NROWS];
	logic                exp_wb_en [NROWS];
	logic [`REG_SEL-1:0] exp_wb_addr [NROWS];
	logic [`XLEN-1:0]    exp_wb_data [NROWS];
	logic                exp_st_en [NROWS];
	logic [`XLEN-1:0]    exp_st_addr [NROWS];
	logic [`XLEN-1:0]    exp_st_data [NROWS];

	// reference architectural state
	logic [`XLEN-1:0] m_regs [`NR_REG];
	logic [`XLEN-1:0] m_pc;
	logic             m_halted;
	int               n_rows;
	int               row;
	int               errors;

	rv_core dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.pc         (pc),
		.halted     (halted),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.store_en   (store_en),
		.store_addr (store_addr),
		.store_data (store_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// (rows + 10) cycles covers reset and the whole table
	initial begin
		#((NROWS + 10) * CLK_PERIOD);
		$display("timeout: the program table did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	function automatic logic [63:0] sign_ext(input int v, input int width);
		logic signed [63:0] t;
		t = 64'(v);
		t = t << (64 - width);
		t = t >>> (64 - width); // arithmetic shift copies the sign bit down
		return t;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: row %0d %s is %h, expected %h", $time, row, name, got, exp);
			errors++;
		end
	endtask

	// encode one instruction and step the model over it
	task automatic add_row(input int kind, input int rd, input int rs1, input int rs2,
			input int imm, input logic [31:0] raw);
		inst_word_u       enc;
		logic [63:0]      a;
		logic [63:0]      b;
		logic [63:0]      wb;
		logic [63:0]      nxt;
		logic             do_wb;
		enc.raw = '0;
		a       = m_regs[rs1[4:0]];
		b       = m_regs[rs2[4:0]];
		wb      = '0;
		nxt     = m_pc + 64'd4;
		do_wb   = 1'b0;
		exp_st_en[n_rows]   = 1'b0;
		exp_st_addr[n_rows] = '0;
		exp_st_data[n_rows] = '0;
		case (kind)
			K_ADDI, K_JALR: begin
				enc.i.imm    = imm[11:0];
				enc.i.rs1    = rs1[4:0];
				enc.i.rd     = rd[4:0];
				enc.i.opcode = (kind == K_ADDI) ? OP_IMM : OP_JALR;
				do_wb        = 1'b1;
				wb           = a + sign_ext(imm, 12);
				if (kind == K_JALR) begin
					wb  = m_pc + 64'd4;
					nxt = (a + sign_ext(imm, 12)) & ~64'd1;
				end
			end
			K_LUI, K_AUIPC: begin
				enc.u.imm    = imm[19:0];
				enc.u.rd     = rd[4:0];
				enc.u.opcode = (kind == K_LUI) ? OP_LUI : OP_AUIPC;
				do_wb        = 1'b1;
				wb           = sign_ext(imm << 12, 32) + ((kind == K_AUIPC) ? m_pc : 64'd0);
			end
			K_JAL: begin
				enc.j.imm20    = imm[20];
				enc.j.imm10_1  = imm[10:1];
				enc.j.imm11    = imm[11];
				enc.j.imm19_12 = imm[19:12];
				enc.j.rd       = rd[4:0];
				enc.j.opcode   = OP_JAL;
				do_wb          = 1'b1;
				wb             = m_pc + 64'd4;
				nxt            = m_pc + sign_ext(imm, 21);
			end
			K_SD: begin
				enc.s.imm_hi = imm[11:5];
				enc.s.imm_lo = imm[4:0];
				enc.s.rs1    = rs1[4:0];
				enc.s.rs2    = rs2[4:0];
				enc.s.funct3 = 3'b011;
				enc.s.opcode = OP_STORE;
				exp_st_en[n_rows]   = !m_halted;
				exp_st_addr[n_rows] = a + sign_ext(imm, 12);
				exp_st_data[n_rows] = b;
			end
			K_EBREAK: begin
				enc.raw = 32'h0010_0073;
				nxt     = m_pc;
			end
			default: enc.raw = raw; // anything outside the decoded set
		endcase
		if (m_halted)
			nxt = m_pc;
		tbl_inst[n_rows]    = enc.raw;
		exp_pc[n_rows]      = m_pc;
		exp_halted[n_rows]  = m_halted;
		exp_wb_en[n_rows]   = do_wb && (rd != 0) && !m_halted;
		exp_wb_addr[n_rows] = rd[4:0];
		exp_wb_data[n_rows] = wb;
		if (exp_wb_en[n_rows])
			m_regs[rd[4:0]] = wb;
		if (kind == K_EBREAK)
			m_halted = 1'b1;
		m_pc = nxt;
		n_rows++;
	endtask

	initial begin
		int r;
		errors = 0;
		row    = -1;
		n_rows = 0;
		rst_n  = 1'b0;
		inst   = 32'h0010_0093; // addi x1, x0, 1 held during reset
		r      = $urandom(27);  // seed
		for (int i = 0; i < `NR_REG; i++)
			m_regs[i] = '0;
		m_pc     = `RESET_PC;
		m_halted = 1'b0;

		r = $urandom();
		add_row(K_ADDI, 1, 0, 0, (r & 'h7FF) | 'h800, 0); // always negative
		r = $urandom();
		add_row(K_ADDI, 2, 0, 0, r & 'hFFF, 0);
		r = $urandom();
		add_row(K_LUI, 3, 0, 0, r & 'hFFFFF, 0);
		r = $urandom();
		add_row(K_AUIPC, 4, 0, 0, (r & 'h7FFFF) | 'h80000, 0);
		add_row(K_ADDI, 0, 1, 0, 5, 0);                 // dropped write to x0
		add_row(K_ADDI, 5, 0, 0, 7, 0);                 // x0 as operand
		r = $urandom();
		add_row(K_SD, 0, 1, 2, r & 'hFFF, 0);
		add_row(K_ILLEGAL, 0, 0, 0, 0, 32'h0020_8333); // add x6, x1, x2
		r = $urandom();
		add_row(K_JAL, 6, 0, 0, r & 'h1FFFFE, 0);
		add_row(K_LUI, 7, 0, 0, 'h80001, 0);
		add_row(K_JALR, 8, 7, 0, 5, 0);                 // odd target has bit 0 cleared
		add_row(K_SD, 0, 7, 4, -8, 0);
		add_row(K_EBREAK, 0, 0, 0, 0, 0);
		add_row(K_ADDI, 9, 0, 0, 1, 0);                 // halted from here on
		add_row(K_SD, 0, 1, 2, 0, 0);

		repeat (4) @(posedge clk);
		@(negedge clk);
		check_val("wb_en in reset", 64'(wb_en), 64'd0);
		inst = 32'h0020_b023; // sd x2, 0(x1) for the store side
		@(negedge clk);
		check_val("store_en in reset", 64'(store_en), 64'd0);
		rst_n = 1'b1;

		for (int i = 0; i < NROWS; i++) begin
			row  = i;
			inst = tbl_inst[i];
			#(CLK_PERIOD/2 - 2); // let outputs settle before the rising edge
			check_val("pc", pc, exp_pc[i]);
			check_val("halted", 64'(halted), 64'(exp_halted[i]));
			check_val("wb_en", 64'(wb_en), 64'(exp_wb_en[i]));
			if (exp_wb_en[i]) begin
				check_val("wb_addr", 64'(wb_addr), 64'(exp_wb_addr[i]));
				check_val("wb_data", wb_data, exp_wb_data[i]);
			end
			check_val("store_en", 64'(store_en), 64'(exp_st_en[i]));
			if (exp_st_en[i]) begin
				check_val("store_addr", store_addr, exp_st_addr[i]);
				check_val("store_data", store_data, exp_st_data[i]);
			end
			@(negedge clk);
		end

		$display("%0d rows run, %0d errors", NROWS, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* src.f */
+incdir+logic
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/gpr_file.sv
logic/inst_decode.sv
logic/exec_unit.sv
logic/fetch_pc.sv
logic/rv_core.sv
testbench/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f src.f --top-module tb_rv_core -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -F '>>> PASS' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
